//--- design/bp_defs.svh
`ifndef BP_DEFS_SVH
`define BP_DEFS_SVH

// address width of the core
`define BP_PC_W 64

// one instruction line, four 32-bit words
`define BP_LINE_BYTES 16

// max slots handed to fetch per group
`define BP_FETCH_W 4

// global history length
`define BP_GHR_K 4

// pc bits taken above the word offset for the table index
`define BP_PC_IDX_N 4

// return address stack entries, power of two
`define BP_RAS_DEPTH 8

`endif

//--- design/bp_pkg.sv
`include "bp_defs.svh"

package bp_pkg;

  typedef logic [`BP_PC_W-1:0] pc_t;                        // byte address
  typedef logic [31:0] instr_t;                             // one fixed-width instruction
  typedef logic [`BP_LINE_BYTES*8-1:0] line_t;              // byte 0 sits in bits 7:0
  typedef logic [1:0] ctr_t;                                // 2-bit saturating counter
  typedef logic [`BP_GHR_K-1:0] ghr_t;                      // global history
  typedef logic [`BP_GHR_K+`BP_PC_IDX_N-1:0] pht_idx_t;     // {history, pc bits}

  // predecode class of one slot, none marks an unused slot
  typedef enum logic [2:0] {
    kind_none,
    kind_plain,
    kind_b,
    kind_bl,
    kind_ret,
    kind_bcond
  } slot_kind_e;

  typedef struct packed {
    slot_kind_e kind;
    pc_t        target;      // zero for plain slots
    logic       pred_taken;
  } slot_info_t;

  typedef struct packed {
    pc_t                              pc;       // pc of the first slot
    line_t                            line;
    logic [2:0]                       count;    // valid slots, 1..fetch width
    slot_info_t [`BP_FETCH_W-1:0]     slots;    // slot 0 at pc
    pc_t                              next_pc;
  } fetch_group_t;

  typedef struct packed {
    pc_t  pc;           // pc of the resolved branch
    logic is_cond;
    logic taken;
    logic mispredict;
    pc_t  correct_pc;   // where fetch should go on a mispredict
  } resolve_t;

  typedef enum logic [1:0] {
    st_idle,
    st_request,
    st_wait_line,
    st_offer
  } seq_state_e;

endpackage

//--- design/branch_pred_top.sv
`timescale 1ns/10ps

module branch_pred_top (
  input  logic                 clk_in,
  input  logic                 rst_N_in,
  input  logic                 start_valid,
  input  bp_pkg::pc_t          start_pc,
  output logic                 line_req_valid,
  input  logic                 line_req_ready,
  output bp_pkg::pc_t          line_req_addr,
  input  logic                 line_rsp_valid,
  input  bp_pkg::line_t        line_rsp,
  output logic                 group_valid,
  input  logic                 group_ready,
  output bp_pkg::fetch_group_t group,
  input  logic                 resolve_valid,
  input  bp_pkg::resolve_t     resolve
);

  bp_pkg::pc_t          pd_pc;
  bp_pkg::line_t        pd_line;
  bp_pkg::fetch_group_t pd_group;
  bp_pkg::pc_t          lookup_pc;    // first b.cond of the group
  logic                 bcond_taken;
  bp_pkg::pc_t          ras_top;
  logic                 ras_push;
  logic                 ras_pop;
  bp_pkg::pc_t          ras_push_addr;

  fetch_sequencer u_seq (
    .clk_in         (clk_in),
    .rst_N_in       (rst_N_in),
    .start_valid    (start_valid),
    .start_pc       (start_pc),
    .resolve_valid  (resolve_valid),
    .resolve        (resolve),
    .line_req_valid (line_req_valid),
    .line_req_ready (line_req_ready),
    .line_req_addr  (line_req_addr),
    .line_rsp_valid (line_rsp_valid),
    .line_rsp       (line_rsp),
    .pd_pc          (pd_pc),
    .pd_line        (pd_line),
    .pd_group       (pd_group),
    .group_valid    (group_valid),
    .group_ready    (group_ready),
    .group          (group),
    .ras_push       (ras_push),
    .ras_pop        (ras_pop),
    .ras_push_addr  (ras_push_addr)
  );

  line_predecoder u_pd (
    .pc          (pd_pc),
    .line        (pd_line),
    .ras_top     (ras_top),
    .bcond_taken (bcond_taken),
    .lookup_pc   (lookup_pc),
    .group       (pd_group)
  );

  gshare_pht u_pht (
    .clk_in        (clk_in),
    .rst_N_in      (rst_N_in),
    .lookup_pc     (lookup_pc),
    .predict_taken (bcond_taken),
    .update_valid  (resolve_valid),  // the table filters on is_cond
    .update        (resolve)
  );

  ras_stack u_ras (
    .clk_in    (clk_in),
    .rst_N_in  (rst_N_in),
    .push      (ras_push),
    .pop       (ras_pop),
    .push_addr (ras_push_addr),
    .top       (ras_top)
  );

endmodule

//--- design/fetch_sequencer.sv
`timescale 1ns/10ps
`include "bp_defs.svh"

module fetch_sequencer (
  input  logic                 clk_in,
  input  logic                 rst_N_in,
  input  logic                 start_valid,
  input  bp_pkg::pc_t          start_pc,
  input  logic                 resolve_valid,
  input  bp_pkg::resolve_t     resolve,
  output logic                 line_req_valid,
  input  logic                 line_req_ready,
  output bp_pkg::pc_t          line_req_addr,
  input  logic                 line_rsp_valid,
  input  bp_pkg::line_t        line_rsp,
  output bp_pkg::pc_t          pd_pc,
  output bp_pkg::line_t        pd_line,
  input  bp_pkg::fetch_group_t pd_group,
  output logic                 group_valid,
  input  logic                 group_ready,
  output bp_pkg::fetch_group_t group,
  output logic                 ras_push,
  output logic                 ras_pop,
  output bp_pkg::pc_t          ras_push_addr
);

  localparam int LINE_LSB = $clog2(`BP_LINE_BYTES);
  localparam int SLOT_W   = $clog2(`BP_FETCH_W);

  bp_pkg::seq_state_e state;
  bp_pkg::seq_state_e state_nxt;
  logic               drop_q;      // response in flight belongs to a dead path
  logic               drop_nxt;
  bp_pkg::pc_t        pc_q;        // fetch pc, start of the offered group
  bp_pkg::pc_t        pc_nxt;
  bp_pkg::pc_t        launch_pc;   // pc the new request is built from
  bp_pkg::pc_t        req_addr_q;  // held separately so a redirect can't move a live request
  bp_pkg::line_t      line_q;
  bp_pkg::pc_t        redir_pc;
  logic               redirect;
  logic               pc_ld;
  logic               line_ld;
  logic               launch;      // issue a fresh line request
  logic               group_hs;
  bp_pkg::slot_info_t last_slot;

  assign redirect = start_valid || (resolve_valid && resolve.mispredict);
  assign redir_pc = start_valid ? start_pc : resolve.correct_pc;

  assign line_req_valid = (state == bp_pkg::st_request);
  assign line_req_addr  = req_addr_q;
  assign group_valid    = (state == bp_pkg::st_offer);
  assign group          = pd_group;  // live predecode of pc_q and line_q
  assign pd_pc          = pc_q;
  assign pd_line        = line_q;

  // a redirect in the same cycle wins over the hand-off
  assign group_hs  = group_valid && group_ready && !redirect;
  assign last_slot = pd_group.slots[SLOT_W'(pd_group.count - 3'd1)];
  assign ras_push  = group_hs && (last_slot.kind == bp_pkg::kind_bl);
  assign ras_pop   = group_hs && (last_slot.kind == bp_pkg::kind_ret);
  // bl closes the group, so the return address is just past the last slot
  assign ras_push_addr = {pd_group.pc[`BP_PC_W-1:2], 2'b00}
                       + (bp_pkg::pc_t'(pd_group.count) << 2);

  always_comb begin
    state_nxt = state;
    drop_nxt  = drop_q;
    pc_nxt    = redir_pc;
    pc_ld     = 1'b0;
    line_ld   = 1'b0;
    launch    = 1'b0;
    case (state)
      bp_pkg::st_idle: begin
        if (redirect) begin
          pc_ld  = 1'b1;
          launch = 1'b1;
        end
      end
      bp_pkg::st_request: begin
        if (redirect) begin
          pc_ld    = 1'b1;
          drop_nxt = 1'b1;  // old request still goes out, its line gets thrown away
        end
        if (line_req_ready) begin
          state_nxt = bp_pkg::st_wait_line;
        end
      end
      bp_pkg::st_wait_line: begin
        if (redirect) begin
          pc_ld = 1'b1;
        end
        if (line_rsp_valid) begin
          if (drop_q || redirect) begin
            drop_nxt = 1'b0;  // stale line discarded, refetch from pc
            launch   = 1'b1;
          end else begin
            line_ld   = 1'b1;
            state_nxt = bp_pkg::st_offer;
          end
        end else if (redirect) begin
          drop_nxt = 1'b1;
        end
      end
      bp_pkg::st_offer: begin
        if (redirect) begin
          pc_ld  = 1'b1;  // offered group dropped
          launch = 1'b1;
        end else if (group_ready) begin
          pc_nxt = pd_group.next_pc;
          pc_ld  = 1'b1;
          launch = 1'b1;
        end
      end
      default: begin
        state_nxt = bp_pkg::st_idle;
      end
    endcase
    if (launch) begin
      state_nxt = bp_pkg::st_request;
    end
    launch_pc = pc_ld ? pc_nxt : pc_q;
  end

  always_ff @(posedge clk_in) begin
    if (rst_N_in) begin
      state  <= bp_pkg::st_idle;
      drop_q <= 1'b0;
    end else begin
      state  <= state_nxt;
      drop_q <= drop_nxt;
    end
  end

  always_ff @(posedge clk_in) begin
    if (pc_ld) begin
      pc_q <= pc_nxt;
    end
    if (launch) begin
      req_addr_q <= {launch_pc[`BP_PC_W-1:LINE_LSB], {LINE_LSB{1'b0}}};  // line aligned
    end
    if (line_ld) begin
      line_q <= line_rsp;
    end
  end

endmodule

//--- design/gshare_pht.sv
`timescale 1ns/10ps
`include "bp_defs.svh"

module gshare_pht (
  input  logic             clk_in,
  input  logic             rst_N_in,
  input  bp_pkg::pc_t      lookup_pc,
  output logic             predict_taken,
  input  logic             update_valid,
  input  bp_pkg::resolve_t update
);

  localparam int ENTRIES = 1 << (`BP_GHR_K + `BP_PC_IDX_N);
  localparam int PC_HI   = `BP_PC_IDX_N + 1;  // word offset dropped, bits PC_HI..2

  bp_pkg::ghr_t     ghr;
  bp_pkg::ctr_t     pht [ENTRIES];
  bp_pkg::pht_idx_t rd_idx;
  bp_pkg::pht_idx_t wr_idx;
  bp_pkg::ctr_t     cur_ctr;  // counter being trained
  bp_pkg::ctr_t     new_ctr;
  logic             train;

  // lookup answers in the same cycle
  assign rd_idx        = {ghr, lookup_pc[PC_HI:2]};
  assign predict_taken = pht[rd_idx][1];  // weakly or strongly taken

  // training uses the history as it stands now, not the one at predict time
  assign wr_idx  = {ghr, update.pc[PC_HI:2]};
  assign cur_ctr = pht[wr_idx];
  assign train   = update_valid && update.is_cond;

  always_comb begin
    new_ctr = cur_ctr;
    if (update.taken) begin
      if (cur_ctr != 2'b11) begin
        new_ctr = cur_ctr + 2'b01;
      end
    end else begin
      if (cur_ctr != 2'b00) begin
        new_ctr = cur_ctr - 2'b01;
      end
    end
  end

  always_ff @(posedge clk_in) begin
    if (rst_N_in) begin
      ghr <= '0;
      for (int i = 0; i < ENTRIES; i++) begin
        pht[i] <= '0;  // all strongly not taken
      end
    end else if (train) begin
      pht[wr_idx] <= new_ctr;
      ghr         <= {ghr[`BP_GHR_K-2:0], update.taken};  // newest outcome in bit 0
    end
  end

endmodule

//--- design/line_predecoder.sv
`timescale 1ns/10ps
`include "bp_defs.svh"

module line_predecoder (
  input  bp_pkg::pc_t          pc,
  input  bp_pkg::line_t        line,
  input  bp_pkg::pc_t          ras_top,
  input  logic                 bcond_taken,
  output bp_pkg::pc_t          lookup_pc,
  output bp_pkg::fetch_group_t group
);

  localparam int WORDS    = `BP_LINE_BYTES / 4;
  localparam int OFF_W    = $clog2(WORDS);
  localparam int LINE_LSB = OFF_W + 2;   // first pc bit above the line offset
  localparam int B_EXT    = `BP_PC_W - 28;  // sign bits above imm26 * 4
  localparam int C_EXT    = `BP_PC_W - 21;  // sign bits above imm19 * 4

  bp_pkg::pc_t        pc_w;    // word aligned start
  logic [2:0]         avail;   // slots left in the line, capped at fetch width
  bp_pkg::slot_kind_e kind   [`BP_FETCH_W];
  bp_pkg::pc_t        slot_pc[`BP_FETCH_W];
  bp_pkg::pc_t        target [`BP_FETCH_W];

  assign pc_w = {pc[`BP_PC_W-1:2], 2'b00};

  always_comb begin
    avail = 3'(WORDS) - 3'(pc[LINE_LSB-1:2]);
    if (avail > 3'(`BP_FETCH_W)) begin
      avail = 3'(`BP_FETCH_W);
    end
  end

  // classify every slot position, the scan below decides which ones count
  always_comb begin : classify
    bp_pkg::instr_t w;
    int             idx;
    for (int i = 0; i < `BP_FETCH_W; i++) begin
      idx        = (int'(pc[LINE_LSB-1:2]) + i) % WORDS;  // wraps past line end, unused
      w          = line[idx*32 +: 32];
      slot_pc[i] = pc_w + (bp_pkg::pc_t'(i) << 2);
      target[i]  = '0;
      if (w[31:21] == 11'b11010110010) begin
        kind[i]   = bp_pkg::kind_ret;
        target[i] = ras_top;  // return predicted from the stack
      end else if (w[31:26] == 6'b000101) begin
        kind[i]   = bp_pkg::kind_b;
        target[i] = slot_pc[i] + {{B_EXT{w[25]}}, w[25:0], 2'b00};
      end else if (w[31:26] == 6'b100101) begin
        kind[i]   = bp_pkg::kind_bl;
        target[i] = slot_pc[i] + {{B_EXT{w[25]}}, w[25:0], 2'b00};
      end else if (w[31:24] == 8'b01010100) begin
        kind[i]   = bp_pkg::kind_bcond;
        target[i] = slot_pc[i] + {{C_EXT{w[23]}}, w[23:5], 2'b00};  // imm19 in 23:5
      end else begin
        kind[i] = bp_pkg::kind_plain;
      end
    end
  end

  // first b.cond ahead of any unconditional branch goes to the table
  // kept apart from the group scan so the table answer feeds back cleanly
  always_comb begin : bcond_lookup
    logic stop;
    stop      = 1'b0;
    lookup_pc = pc_w;  // don't care when the group has no b.cond
    for (int i = 0; i < `BP_FETCH_W; i++) begin
      if ((3'(i) < avail) && !stop) begin
        if (kind[i] == bp_pkg::kind_bcond) begin
          lookup_pc = slot_pc[i];
          stop      = 1'b1;
        end else if (kind[i] != bp_pkg::kind_plain) begin
          stop = 1'b1;  // group ends before any b.cond
        end
      end
    end
  end

  always_comb begin : build_group
    logic       done;
    logic       seen_bcond;
    logic [2:0] cnt;
    done          = 1'b0;
    seen_bcond    = 1'b0;
    cnt           = '0;
    group         = '0;  // unused slots read as kind_none
    group.pc      = pc;
    group.line    = line;
    for (int i = 0; i < `BP_FETCH_W; i++) begin
      if ((3'(i) < avail) && !done) begin
        group.slots[i].kind   = kind[i];
        group.slots[i].target = target[i];
        cnt = cnt + 3'd1;
        case (kind[i])
          bp_pkg::kind_b, bp_pkg::kind_bl, bp_pkg::kind_ret: begin
            group.slots[i].pred_taken = 1'b1;  // always taken
            group.next_pc             = target[i];
            done                      = 1'b1;
          end
          bp_pkg::kind_bcond: begin
            if (!seen_bcond) begin
              group.slots[i].pred_taken = bcond_taken;  // later ones stay not taken
            end
            seen_bcond = 1'b1;
            if (group.slots[i].pred_taken) begin
              group.next_pc = target[i];
              done          = 1'b1;
            end
          end
          default: begin
          end
        endcase
      end
    end
    group.count = cnt;
    if (!done) begin
      group.next_pc = pc_w + (bp_pkg::pc_t'(cnt) << 2);  // fall through past last slot
    end
  end

endmodule

//--- design/ras_stack.sv
`timescale 1ns/10ps
`include "bp_defs.svh"

module ras_stack (
  input  logic        clk_in,
  input  logic        rst_N_in,
  input  logic        push,
  input  logic        pop,
  input  bp_pkg::pc_t push_addr,
  output bp_pkg::pc_t top
);

  localparam int PTR_W = $clog2(`BP_RAS_DEPTH);
  localparam int CNT_W = $clog2(`BP_RAS_DEPTH + 1);

  bp_pkg::pc_t mem [`BP_RAS_DEPTH];  // circular, oldest entry overwritten when full

  logic [PTR_W-1:0] ptr;      // next free slot
  logic [PTR_W-1:0] top_idx;  // most recent entry
  logic [CNT_W-1:0] count;    // live entries, saturates at depth

  assign top_idx = ptr - PTR_W'(1);

  // empty stack predicts address zero
  assign top = (count == '0) ? '0 : mem[top_idx];

  always_ff @(posedge clk_in) begin
    if (push) begin
      mem[ptr] <= push_addr;
    end
  end

  always_ff @(posedge clk_in) begin
    if (rst_N_in) begin
      ptr   <= '0;
      count <= '0;
    end else if (push) begin
      ptr <= ptr + PTR_W'(1);  // wraps over the oldest entry
      if (count != CNT_W'(`BP_RAS_DEPTH)) begin
        count <= count + CNT_W'(1);
      end
    end else if (pop) begin
      if (count == '0) begin
        ptr <= '0;  // underflow, stays empty
      end else begin
        ptr   <= top_idx;
        count <= count - CNT_W'(1);
      end
    end
  end

endmodule

//--- run_sim.sh
#!/bin/bash
set -e
cd "$(dirname "$0")"

verilator --binary --timing -f tb.f --top-module branch_pred_tb -o branch_pred_sim

out=$(./obj_dir/branch_pred_sim 2>&1) || true
echo "$out"

if grep -q "No errors" <<< "$out"; then
  exit 0
fi
exit 1

//--- tb.f
+incdir+design
design/bp_pkg.sv
design/ras_stack.sv
design/gshare_pht.sv
design/line_predecoder.sv
design/fetch_sequencer.sv
design/branch_pred_top.sv
verif/branch_pred_tb.sv

//--- verif/branch_pred_tb.sv
`timescale 1ns/10ps
`include "bp_defs.svh"

module branch_pred_tb;

  localparam int NSTEPS = 11;
  localparam logic [2:0] A_START = 3'd0;
  localparam logic [2:0] A_ACCEPT = 3'd1;
  localparam logic [2:0] A_STALL = 3'd2;
  localparam logic [2:0] A_RESOLVE = 3'd3;
  localparam logic [2:0] A_ACC_REDIR = 3'd4;  // accept then mispredict
  localparam logic [2:0] K_N = 3'(bp_pkg::kind_none);
  localparam logic [2:0] K_P = 3'(bp_pkg::kind_plain);
  localparam logic [2:0] K_B = 3'(bp_pkg::kind_b);
  localparam logic [2:0] K_BL = 3'(bp_pkg::kind_bl);
  localparam logic [2:0] K_RET = 3'(bp_pkg::kind_ret);
  localparam logic [2:0] K_BC = 3'(bp_pkg::kind_bcond);

  typedef struct packed {
    logic [2:0]       act;
    logic [7:0]       arg;       // stall cycles or resolve repeats
    bp_pkg::pc_t      pc_a;      // start pc or resolved branch pc
    bp_pkg::pc_t      pc_b;      // correct pc
    logic [2:0]       rflags;    // is_cond, taken, mispredict
    bp_pkg::pc_t      exp_pc;
    logic [2:0]       exp_cnt;   // assuming the b.cond falls through
    bp_pkg::pc_t      exp_next;
    logic [3:0][2:0]  kinds;     // slot 0 in the low bits
    logic [1:0]       pred;      // bit0 uses the ras model and bit1 the counter model
    bp_pkg::pc_t      bc_pc;
    bp_pkg::pc_t      bc_tgt;
  } step_t;

  logic clk_in = 1'b0;
  logic rst_N_in;
  logic start_valid;
  logic line_req_valid;
  logic line_req_ready;
  logic line_rsp_valid;
  logic group_valid;
  logic group_ready;
  logic resolve_valid;
  bp_pkg::pc_t start_pc;
  bp_pkg::pc_t line_req_addr;
  bp_pkg::line_t line_rsp;
  bp_pkg::fetch_group_t group;
  bp_pkg::resolve_t resolve;

  step_t steps [NSTEPS];
  logic [15:0] lfsr = 16'd35667;
  logic [1:0] m_ctr [256];          // counter model
  logic [3:0] m_ghr = '0;
  bp_pkg::pc_t ras_q [$];           // stack model, newest at the back
  bp_pkg::pc_t cur_pc;              // last checked group
  logic [2:0] cur_cnt;
  logic [3:0][2:0] cur_kinds;

  branch_pred_top dut (.*);

  initial begin
    forever #20 clk_in = ~clk_in;
  end

  // x^16 + x^14 + x^13 + x^11 + 1
  function automatic logic [7:0] lfsr_bits(input int n);
    logic [7:0] r;
    logic fb;
    r = '0;
    for (int i = 0; i < n; i++) begin
      fb   = lfsr[15] ^ lfsr[13] ^ lfsr[12] ^ lfsr[10];
      lfsr = {lfsr[14:0], fb};
      r    = {r[6:0], fb};
    end
    return r;
  endfunction

  function automatic bp_pkg::instr_t word_at(input bp_pkg::pc_t a);
    case (a)
      64'h1014: return 32'h940003FB;  // bl 0x2000
      64'h2000: return 32'hD65F03C0;  // ret
      64'h1020: return 32'h140007F8;  // b 0x3000
      64'h3004: return 32'h540007E0;  // b.cond 0x3100
      64'h300C: return 32'hD65F03C0;
      default:  return {8'hD5, a[23:0] ^ a[47:24] ^ {8'h00, a[63:48]}};  // plain filler
    endcase
  endfunction

  function automatic bp_pkg::line_t line_at(input bp_pkg::pc_t a);
    bp_pkg::line_t l;
    for (int i = 0; i < 4; i++) l[i*32 +: 32] = word_at(a + 64'(i * 4));
    return l;
  endfunction

  task automatic check(input string name, input logic [63:0] got, input logic [63:0] exp);
    if (got !== exp) begin
      $display("Mismatch at %0t: %s got %h expected %h", $time, name, got, exp);
      $display("Errors found");
      $fatal(1);
    end
  endtask

  initial begin : mem_responder
    bp_pkg::pc_t addr;
    logic [7:0] delay;
    line_req_ready = 1'b0;
    line_rsp_valid = 1'b0;
    line_rsp       = '0;
    forever begin
      @(negedge clk_in);
      line_rsp_valid = 1'b0;
      line_req_ready = (lfsr_bits(1) != 8'd0);
      if (line_req_ready && line_req_valid) begin  // transfer at the coming edge
        addr  = line_req_addr;
        delay = lfsr_bits(2);
        @(negedge clk_in);
        line_req_ready = 1'b0;
        repeat (int'(delay)) @(negedge clk_in);
        line_rsp       = line_at(addr);
        line_rsp_valid = 1'b1;
      end
    end
  end

  initial begin : watchdog
    repeat ((NSTEPS + 1) * 40) @(posedge clk_in);
    $display("Timeout: no result after 40 cycles per table step");
    $display("Errors found");
    $fatal(1);
  end

  task automatic wait_group();
    while (!group_valid) @(negedge clk_in);
  endtask

  task automatic check_group(input step_t s);
    logic [2:0] cnt;
    bp_pkg::pc_t nxt;
    logic [3:0][2:0] kinds;
    int slot;
    logic bc_taken;
    logic exp_taken;
    bp_pkg::pc_t exp_tgt;
    bp_pkg::line_t exp_line;
    cnt      = s.exp_cnt;
    nxt      = s.exp_next;
    kinds    = s.kinds;
    exp_line = line_at({s.exp_pc[63:4], 4'h0});
    if (s.pred[0]) nxt = (ras_q.size() > 0) ? ras_q[$] : '0;  // empty stack gives zero
    bc_taken = s.pred[1] && m_ctr[{m_ghr, s.bc_pc[5:2]}][1];
    if (bc_taken) begin
      slot = int'((s.bc_pc - s.exp_pc) >> 2);
      cnt  = 3'(slot + 1);
      nxt  = s.bc_tgt;
      for (int j = slot + 1; j < 4; j++) kinds[j] = K_N;  // group ends at taken b.cond
    end
    check("group.pc", group.pc, s.exp_pc);
    check("group.count", 64'(group.count), 64'(cnt));
    check("group.next_pc", group.next_pc, nxt);
    check("group.line[63:0]", group.line[63:0], exp_line[63:0]);  // stale line shows here
    check("group.line[127:64]", group.line[127:64], exp_line[127:64]);
    for (int i = 0; i < 4; i++) begin
      exp_taken = (kinds[i] == K_B) || (kinds[i] == K_BL) || (kinds[i] == K_RET)
                || ((kinds[i] == K_BC) && bc_taken);
      case (kinds[i])
        K_B, K_BL, K_RET: exp_tgt = nxt;  // the closing branch gives next_pc
        K_BC:             exp_tgt = s.bc_tgt;
        default:          exp_tgt = '0;
      endcase
      check($sformatf("group.slots[%0d].kind", i), 64'(group.slots[i].kind), 64'(kinds[i]));
      check($sformatf("group.slots[%0d].target", i), group.slots[i].target, exp_tgt);
      check($sformatf("group.slots[%0d].pred_taken", i), 64'(group.slots[i].pred_taken),
            64'(exp_taken));
    end
    cur_pc    = s.exp_pc;
    cur_cnt   = cnt;
    cur_kinds = kinds;
  endtask

  task automatic accept_group();
    logic [2:0] last;
    bp_pkg::pc_t last_pc;
    last    = cur_kinds[cur_cnt - 3'd1];
    last_pc = {cur_pc[63:2], 2'b00} + 64'(cur_cnt - 3'd1) * 64'd4;  // closing slot address
    if (last == K_BL) begin
      ras_q.push_back(last_pc + 64'd4);  // return lands after the bl
      if (ras_q.size() > `BP_RAS_DEPTH) void'(ras_q.pop_front());  // oldest lost
    end else if (last == K_RET && ras_q.size() > 0) begin
      void'(ras_q.pop_back());
    end
    group_ready = 1'b1;
    @(negedge clk_in);
    group_ready = 1'b0;
    check("line_req_valid", 64'(line_req_valid), 64'd1);
  endtask

  task automatic drive_resolve(input step_t s, input int reps);
    for (int r = 0; r < reps; r++) begin
      resolve_valid = 1'b1;
      resolve       = '{pc: s.pc_a, is_cond: s.rflags[2], taken: s.rflags[1],
                        mispredict: s.rflags[0], correct_pc: s.pc_b};
      if (s.rflags[2]) begin  // counter and history model
        if (s.rflags[1] && m_ctr[{m_ghr, s.pc_a[5:2]}] != 2'd3)
          m_ctr[{m_ghr, s.pc_a[5:2]}] += 2'd1;
        else if (!s.rflags[1] && m_ctr[{m_ghr, s.pc_a[5:2]}] != 2'd0)
          m_ctr[{m_ghr, s.pc_a[5:2]}] -= 2'd1;
        m_ghr = {m_ghr[2:0], s.rflags[1]};
      end
      @(negedge clk_in);
    end
    resolve_valid = 1'b0;
    if (s.rflags[0]) check("group_valid", 64'(group_valid), 64'd0);
  endtask

  initial begin : main
    step_t s;
    rst_N_in = 1'b1;
    start_valid = 1'b0;
    start_pc = '0;
    group_ready = 1'b0;
    resolve_valid = 1'b0;
    resolve = '0;
    for (int i = 0; i < 256; i++) m_ctr[i] = 2'd0;
    steps[0]  = '{A_START, 8'd0, 64'h1008, 64'h0, 3'b000, 64'h1008, 3'd2, 64'h1010,
                  {K_N, K_N, K_P, K_P}, 2'b00, 64'h0, 64'h0};
    steps[1]  = '{A_ACCEPT, 8'd0, 64'h0, 64'h0, 3'b000, 64'h1010, 3'd2, 64'h2000,
                  {K_N, K_N, K_BL, K_P}, 2'b00, 64'h0, 64'h0};
    steps[2]  = '{A_STALL, 8'd5, 64'h0, 64'h0, 3'b000, 64'h1010, 3'd2, 64'h2000,
                  {K_N, K_N, K_BL, K_P}, 2'b00, 64'h0, 64'h0};
    steps[3]  = '{A_ACCEPT, 8'd0, 64'h0, 64'h0, 3'b000, 64'h2000, 3'd1, 64'h0,
                  {K_N, K_N, K_N, K_RET}, 2'b01, 64'h0, 64'h0};
    steps[4]  = '{A_ACCEPT, 8'd0, 64'h0, 64'h0, 3'b000, 64'h1018, 3'd2, 64'h1020,
                  {K_N, K_N, K_P, K_P}, 2'b00, 64'h0, 64'h0};
    steps[5]  = '{A_ACCEPT, 8'd0, 64'h0, 64'h0, 3'b000, 64'h1020, 3'd1, 64'h3000,
                  {K_N, K_N, K_N, K_B}, 2'b00, 64'h0, 64'h0};
    steps[6]  = '{A_ACCEPT, 8'd0, 64'h0, 64'h0, 3'b000, 64'h3000, 3'd4, 64'h0,
                  {K_RET, K_P, K_BC, K_P}, 2'b11, 64'h3004, 64'h3100};
    steps[7]  = '{A_RESOLVE, 8'd6, 64'h3004, 64'h0, 3'b110, 64'h3000, 3'd4, 64'h0,
                  {K_RET, K_P, K_BC, K_P}, 2'b11, 64'h3004, 64'h3100};
    steps[8]  = '{A_RESOLVE, 8'd1, 64'h3004, 64'h4000, 3'b001, 64'h4000, 3'd4, 64'h4010,
                  {K_P, K_P, K_P, K_P}, 2'b00, 64'h0, 64'h0};
    steps[9]  = '{A_ACC_REDIR, 8'd1, 64'h4008, 64'h5004, 3'b001, 64'h5004, 3'd3, 64'h5010,
                  {K_N, K_P, K_P, K_P}, 2'b00, 64'h0, 64'h0};
    steps[10] = '{A_ACCEPT, 8'd0, 64'h0, 64'h0, 3'b000, 64'h5010, 3'd4, 64'h5020,
                  {K_P, K_P, K_P, K_P}, 2'b00, 64'h0, 64'h0};
    repeat (4) @(negedge clk_in);
    rst_N_in = 1'b0;
    for (int i = 0; i < NSTEPS; i++) begin
      s = steps[i];
      case (s.act)
        A_START: begin
          start_valid = 1'b1;
          start_pc    = s.pc_a;
          @(negedge clk_in);
          start_valid = 1'b0;
          check("line_req_valid", 64'(line_req_valid), 64'd1);
        end
        A_ACCEPT: accept_group();
        A_STALL: begin
          bp_pkg::fetch_group_t held;
          held = group;
          repeat (int'(s.arg)) begin
            @(negedge clk_in);
            check("group held", 64'(group == held), 64'd1);
            check("group_valid", 64'(group_valid), 64'd1);
            check("line_req_valid", 64'(line_req_valid), 64'd0);
          end
        end
        A_RESOLVE: drive_resolve(s, int'(s.arg));
        default: begin
          accept_group();  // request now outstanding
          drive_resolve(s, int'(s.arg));
        end
      endcase
      wait_group();
      check_group(s);
    end
    $display("No errors");
    $finish;
  end

endmodule
